// File: list.f
+incdir+verif
rtl/super6502_pkg.sv
rtl/bus_addr_decode.sv
rtl/mult_unit.sv
rtl/interval_timer.sv
rtl/irq_controller.sv
rtl/bus_read_mux.sv
rtl/cpu_periph_top.sv
verif/tb_cpu_periph.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

TOP=tb_cpu_periph
OBJ_DIR=obj_dir
LOG=sim.log

if ! verilator --binary --timing --assert --timescale 1ns/100ps \
        --top-module "$TOP" --Mdir "$OBJ_DIR" -f list.f; then
    echo "Verilator build failed"
    exit 1
fi

"./$OBJ_DIR/V$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "All checks passed" "$LOG"; then
    echo "PASS"
    exit 0
fi
echo "FAIL"
exit 1

// File: verif/tb_cpu_periph_model.svh
`ifndef TB_CPU_PERIPH_MODEL_SVH
`define TB_CPU_PERIPH_MODEL_SVH

// Shadow copies of the peripheral registers
logic [7:0]  m_mult_a;
logic [7:0]  m_mult_b;
logic [15:0] m_reload;
logic [15:0] m_count;                               // Tracked only while the timer is stopped
logic [1:0]  m_tmr_ctrl;
logic        m_tmr_flag;
logic [7:0]  m_irq_mask;

function automatic void clear_shadow();
    m_mult_a   = 8'h00;
    m_mult_b   = 8'h00;
    m_reload   = 16'h0000;
    m_count    = 16'h0000;
    m_tmr_ctrl = 2'b00;
    m_tmr_flag = 1'b0;
    m_irq_mask = 8'h00;
endfunction

function automatic void track_write(input logic [15:0] addr, input logic [7:0] data);
    case (addr)
        16'h7FF0: m_mult_a = data;
        16'h7FF1: m_mult_b = data;
        16'h7FF4: m_reload[7:0] = data;
        16'h7FF5: m_reload[15:8] = data;
        16'h7FF6: begin
            m_tmr_ctrl = data[1:0];
            if (data[0]) begin
                m_count = m_reload;                 // Enable write loads the counter
            end
        end
        16'h7FF7: begin
            if (data[0]) begin
                m_tmr_flag = 1'b0;
            end
        end
        16'h7FF8: m_irq_mask = data;
        default: ;
    endcase
endfunction

// Source 0 is the timer, source 1 the inverted external line
function automatic logic [7:0] predict_pending(input logic ext_n);
    return m_irq_mask & {6'b000000, ~ext_n, m_tmr_flag & m_tmr_ctrl[1]};
endfunction

// Product bytes hold only once an edge has passed after the last operand write
function automatic logic [7:0] predict_read(input logic [15:0] addr, input logic ext_n);
    logic [15:0] prod;
    prod = {8'h00, m_mult_a} * {8'h00, m_mult_b};
    case (addr)
        16'h7FF0: return m_mult_a;
        16'h7FF1: return m_mult_b;
        16'h7FF2: return prod[7:0];
        16'h7FF3: return prod[15:8];
        16'h7FF4: return m_count[7:0];
        16'h7FF5: return m_count[15:8];
        16'h7FF6: return {6'b000000, m_tmr_ctrl};
        16'h7FF7: return {7'b0000000, m_tmr_flag};
        16'h7FF8: return m_irq_mask;
        16'h7FF9: return predict_pending(ext_n);
        default:  return 8'h00;
    endcase
endfunction

`endif

// File: verif/tb_cpu_periph.sv
`timescale 1ns/100ps

module tb_cpu_periph;
    import super6502_pkg::*;

    localparam int CLK_PERIOD     = 100;
    localparam int NUM_MULT       = 40;
    localparam int NUM_UNMAPPED   = 40;
    localparam int NUM_IRQ        = 24;
    localparam int MAX_RELOAD     = 10;
    localparam int PLANNED_CYCLES = 20 + NUM_MULT * 7 + NUM_UNMAPPED + 15
                                    + 2 * (3 * MAX_RELOAD + 20) + 10 + NUM_IRQ * 3;
    localparam int MARGIN_CYCLES  = 100;

    logic        clk_2;
    logic        i_rst_n;
    bus_req_t    i_req;
    logic        i_ext_irq_n;
    logic [7:0]  o_rdata;
    logic        o_irq_n;

    integer      seed;
    int          errors;
    int          checks;
    logic        ext_level;                         // Level applied to i_ext_irq_n each cycle

    `include "tb_cpu_periph_model.svh"

    cpu_periph_top i_dut (
        .clk_2       (clk_2),
        .i_rst_n     (i_rst_n),
        .i_req       (i_req),
        .i_ext_irq_n (i_ext_irq_n),
        .o_rdata     (o_rdata),
        .o_irq_n     (o_irq_n)
    );

    initial begin
        clk_2 = 1'b0;
        forever #(CLK_PERIOD / 2) clk_2 = ~clk_2;
    end

    initial begin
        #((PLANNED_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles without reaching the end of the tests",
                 PLANNED_CYCLES + MARGIN_CYCLES);
        $display("Checks failed");
        $finish;
    end

    //////////////////////////////////////////////////
    // Bus access
    //////////////////////////////////////////////////

    function automatic logic [31:0] random_bits();
        return $random(seed);
    endfunction

    task automatic check(input string name, input logic [7:0] expected, input logic [7:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // Drive on the falling edge, sample a quarter period later
    task automatic bus_cycle(input logic [15:0] addr, input logic [7:0] wdata, input logic rwb,
                             output logic [7:0] rdata);
        @(negedge clk_2);
        i_ext_irq_n = ext_level;
        i_req.addr  = addr;
        i_req.wdata = wdata;
        i_req.rwb   = rwb;
        i_req.valid = 1'b1;
        i_req.spare = 1'b0;
        #(CLK_PERIOD / 4);
        rdata = o_rdata;
        if (!rwb) begin
            track_write(addr, wdata);
        end
    endtask

    task automatic idle_cycle();
        @(negedge clk_2);
        i_ext_irq_n = ext_level;
        i_req.valid = 1'b0;
        i_req.rwb   = 1'b1;
        #(CLK_PERIOD / 4);
    endtask

    task automatic write_reg(input logic [15:0] addr, input logic [7:0] data);
        logic [7:0] unused_rd;
        bus_cycle(addr, data, 1'b0, unused_rd);
    endtask

    task automatic read_reg(input logic [15:0] addr, output logic [7:0] data);
        bus_cycle(addr, 8'h00, 1'b1, data);
    endtask

    task automatic expect_reg(input string name, input logic [15:0] addr);
        logic [7:0] exp;
        logic [7:0] rd;
        exp = predict_read(addr, ext_level);
        read_reg(addr, rd);
        check($sformatf("%s @%h", name, addr), exp, rd);
    endtask

    task automatic sweep_mapped(input string name);
        logic [15:0] addr;
        addr = 16'h7FF0;
        repeat (10) begin
            expect_reg(name, addr);
            addr = addr + 16'h0001;
        end
    endtask

    //////////////////////////////////////////////////
    // Tests
    //////////////////////////////////////////////////

    task automatic reset_values();
        idle_cycle();
        check("irq_n after reset", 8'h01, {7'b0000000, o_irq_n});
        sweep_mapped("register after reset");
    endtask

    task automatic multiply_pairs();
        logic [31:0] r;
        repeat (NUM_MULT) begin
            r = random_bits();
            case (r[17:16])
                2'd0: begin
                    write_reg(16'h7FF0, r[7:0]);
                    write_reg(16'h7FF1, r[15:8]);
                end
                2'd1: begin
                    write_reg(16'h7FF1, r[15:8]);
                    write_reg(16'h7FF0, r[7:0]);
                end
                2'd2:    write_reg(16'h7FF0, r[7:0]);
                default: write_reg(16'h7FF1, r[15:8]);
            endcase
            idle_cycle();                           // Product lands one edge after the write
            expect_reg("mult product low", 16'h7FF2);
            expect_reg("mult product high", 16'h7FF3);
            expect_reg("mult operand a", 16'h7FF0);
            expect_reg("mult operand b", 16'h7FF1);
        end
    endtask

    task automatic unmapped_access();
        logic [31:0] r;
        logic [31:0] off;
        logic [15:0] addr;
        logic [7:0]  rd;
        r = random_bits();
        write_reg(16'h7FF8, r[7:0] | 8'h01);        // Nonzero mask to watch
        repeat (NUM_UNMAPPED) begin
            r = random_bits();
            if (r[31]) begin
                off  = r % 32'd6;
                addr = 16'h7FFA + off[15:0];        // Hole above the interrupt controller
            end else begin
                addr = r[15:0];
                if (addr >= 16'h7FF0 && addr <= 16'h7FF9) begin
                    addr = addr ^ 16'h8000;
                end
            end
            bus_cycle(addr, r[23:16], r[30], rd);
            check($sformatf("unmapped read data @%h", addr), 8'h00, rd);
        end
        sweep_mapped("register after unmapped traffic");
    endtask

    task automatic timer_expiry();
        logic [31:0] r;
        logic [7:0]  rd;
        int          n;
        int          k;
        r = random_bits();
        n = int'(r[2:0]) + 3;
        write_reg(16'h7FF4, n[7:0]);
        write_reg(16'h7FF5, 8'h00);
        write_reg(16'h7FF6, 8'h01);                 // Load edge E
        for (k = 0; k <= n + 1; k++) begin
            read_reg(16'h7FF7, rd);
            check($sformatf("timer stat after edge %0d of %0d", k, n),
                  (k == n + 1) ? 8'h01 : 8'h00, rd);
        end
        write_reg(16'h7FF7, 8'h01);
        read_reg(16'h7FF7, rd);
        check("timer stat after clear", 8'h00, rd);
        write_reg(16'h7FF6, 8'h00);
        write_reg(16'h7FF7, 8'h01);
    endtask

    task automatic timer_interrupt();
        logic [31:0] r;
        logic [7:0]  rd;
        logic        seen;
        int          n;
        int          k;
        r = random_bits();
        n = int'(r[2:0]) + 3;
        write_reg(16'h7FF8, 8'h01);
        write_reg(16'h7FF4, n[7:0]);
        write_reg(16'h7FF5, 8'h00);
        write_reg(16'h7FF6, 8'h03);                 // Enable with interrupt request
        for (k = 0; k <= n + 1; k++) begin
            read_reg(16'h7FF7, rd);
            check("timer irq flag", (k == n + 1) ? 8'h01 : 8'h00, rd);
            check("timer irq_n before expiry", 8'h01, {7'b0000000, o_irq_n});
        end
        idle_cycle();
        check("timer irq_n after expiry", 8'h00, {7'b0000000, o_irq_n});
        write_reg(16'h7FF7, 8'h01);
        idle_cycle();
        check("timer irq_n on flag clear edge", 8'h00, {7'b0000000, o_irq_n});
        idle_cycle();
        check("timer irq_n after flag clear", 8'h01, {7'b0000000, o_irq_n});

        // Wait for the next expiry, then drop the mask instead
        seen = 1'b0;
        for (k = 0; k < 2 * n + 4 && !seen; k++) begin
            read_reg(16'h7FF7, rd);
            seen = rd[0];
        end
        if (!seen) begin
            errors++;
            $display("Timer flag did not set again within %0d cycles", 2 * n + 4);
        end else begin
            idle_cycle();
            check("timer irq_n before mask clear", 8'h00, {7'b0000000, o_irq_n});
            write_reg(16'h7FF8, 8'h00);
            idle_cycle();
            check("timer irq_n on mask clear edge", 8'h00, {7'b0000000, o_irq_n});
            idle_cycle();
            check("timer irq_n after mask clear", 8'h01, {7'b0000000, o_irq_n});
        end
        write_reg(16'h7FF6, 8'h00);
        write_reg(16'h7FF7, 8'h01);
    endtask

    task automatic external_interrupt();
        logic [31:0] r;
        r = random_bits();
        ext_level = 1'b1;
        write_reg(16'h7FF8, r[7:0] | 8'h02);
        idle_cycle();
        check("ext irq_n while idle", 8'h01, {7'b0000000, o_irq_n});
        ext_level = 1'b0;
        expect_reg("ext pending asserted", 16'h7FF9);
        check("ext irq_n same cycle", 8'h01, {7'b0000000, o_irq_n});
        idle_cycle();
        check("ext irq_n one edge later", 8'h00, {7'b0000000, o_irq_n});
        ext_level = 1'b1;
        expect_reg("ext pending released", 16'h7FF9);
        idle_cycle();
        check("ext irq_n released", 8'h01, {7'b0000000, o_irq_n});
        repeat (NUM_IRQ) begin
            r = random_bits();
            ext_level = r[8];
            write_reg(16'h7FF8, r[7:0]);
            expect_reg("random pending", 16'h7FF9);
            expect_reg("random mask", 16'h7FF8);
            check("random irq_n", {7'b0000000, ~|(predict_pending(ext_level))},
                  {7'b0000000, o_irq_n});
        end
        ext_level = 1'b1;
    endtask

    //////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////

    initial begin
        seed        = 29;
        errors      = 0;
        checks      = 0;
        ext_level   = 1'b1;
        i_rst_n     = 1'b0;
        i_req       = '0;
        i_req.rwb   = 1'b1;
        i_ext_irq_n = 1'b1;
        clear_shadow();
        repeat (4) @(posedge clk_2);
        @(negedge clk_2);
        i_rst_n = 1'b1;

        reset_values();
        multiply_pairs();
        unmapped_access();
        timer_expiry();
        timer_interrupt();
        external_interrupt();

        $display("Errors: %0d in %0d checks", errors, checks);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: rtl/cpu_periph_top.sv
`timescale 1ns/100ps

module cpu_periph_top (
    input  logic                               clk_2,
    input  logic                               i_rst_n,
    input  super6502_pkg::bus_req_t            i_req,
    input  logic                               i_ext_irq_n,
    output logic [super6502_pkg::DATA_W-1:0]   o_rdata,
    output logic                               o_irq_n
);
    import super6502_pkg::*;

    periph_sel_t            w_sel;
    logic [DATA_W-1:0]      w_mult_rdata;
    logic [DATA_W-1:0]      w_timer_rdata;
    logic [DATA_W-1:0]      w_irq_rdata;
    logic                   w_timer_irq;
    logic [IRQ_SOURCES-1:0] w_irq_src;

    always_comb begin
        w_irq_src                = '0;             // Unused sources stay quiet
        w_irq_src[IRQ_SRC_TIMER] = w_timer_irq;
        w_irq_src[IRQ_SRC_EXT]   = ~i_ext_irq_n;
    end

    bus_addr_decode u_bus_addr_decode (
        .i_req (i_req),
        .o_sel (w_sel)
    );

    mult_unit u_mult_unit (
        .clk_2     (clk_2),
        .i_rst_n   (i_rst_n),
        .i_cs      (w_sel.mult_cs),
        .i_rwb     (i_req.rwb),
        .i_valid   (i_req.valid),
        .i_reg_off (w_sel.reg_off),
        .i_wdata   (i_req.wdata),
        .o_rdata   (w_mult_rdata)
    );

    interval_timer u_interval_timer (
        .clk_2     (clk_2),
        .i_rst_n   (i_rst_n),
        .i_cs      (w_sel.timer_cs),
        .i_rwb     (i_req.rwb),
        .i_valid   (i_req.valid),
        .i_reg_off (w_sel.reg_off),
        .i_wdata   (i_req.wdata),
        .o_rdata   (w_timer_rdata),
        .o_irq     (w_timer_irq)
    );

    irq_controller u_irq_controller (
        .clk_2     (clk_2),
        .i_rst_n   (i_rst_n),
        .i_cs      (w_sel.irq_cs),
        .i_rwb     (i_req.rwb),
        .i_valid   (i_req.valid),
        .i_reg_off (w_sel.reg_off),
        .i_wdata   (i_req.wdata),
        .i_src     (w_irq_src),
        .o_rdata   (w_irq_rdata),
        .o_irq_n   (o_irq_n)
    );

    bus_read_mux u_bus_read_mux (
        .i_sel         (w_sel),
        .i_mult_rdata  (w_mult_rdata),
        .i_timer_rdata (w_timer_rdata),
        .i_irq_rdata   (w_irq_rdata),
        .o_rdata       (o_rdata)
    );

endmodule

// File: rtl/bus_read_mux.sv
`timescale 1ns/100ps

module bus_read_mux (
    input  super6502_pkg::periph_sel_t         i_sel,
    input  logic [super6502_pkg::DATA_W-1:0]   i_mult_rdata,
    input  logic [super6502_pkg::DATA_W-1:0]   i_timer_rdata,
    input  logic [super6502_pkg::DATA_W-1:0]   i_irq_rdata,
    output logic [super6502_pkg::DATA_W-1:0]   o_rdata
);
    import super6502_pkg::*;

    logic [DATA_W-1:0] w_rdata;

    //////////////////////////////////////////////////
    // Priority select, unmapped reads return zero
    //////////////////////////////////////////////////

    always_comb begin
        if (i_sel.mult_cs) begin
            w_rdata = i_mult_rdata;
        end else if (i_sel.timer_cs) begin
            w_rdata = i_timer_rdata;
        end else if (i_sel.irq_cs) begin
            w_rdata = i_irq_rdata;
        end else begin
            w_rdata = '0;
        end
    end

    assign o_rdata = w_rdata;

endmodule

// File: rtl/irq_controller.sv
`timescale 1ns/100ps

module irq_controller (
    input  logic                                 clk_2,
    input  logic                                 i_rst_n,
    input  logic                                 i_cs,
    input  logic                                 i_rwb,
    input  logic                                 i_valid,
    input  logic [1:0]                           i_reg_off,
    input  logic [super6502_pkg::DATA_W-1:0]     i_wdata,
    input  logic [super6502_pkg::IRQ_SOURCES-1:0] i_src,
    output logic [super6502_pkg::DATA_W-1:0]     o_rdata,
    output logic                                 o_irq_n
);
    import super6502_pkg::*;

    logic [IRQ_SOURCES-1:0] r_mask;
    logic [IRQ_SOURCES-1:0] w_pend;
    logic                   w_wr;

    assign w_wr   = i_valid & ~i_rwb & i_cs;
    assign w_pend = i_src & r_mask;                 // Level sensitive, no latching

    //////////////////////////////////////////////////
    // Mask register and CPU interrupt line
    //////////////////////////////////////////////////

    always_ff @(posedge clk_2) begin
        if (!i_rst_n) begin
            r_mask <= '0;
        end else if (w_wr && i_reg_off == IRQ_MASK) begin
            r_mask <= i_wdata[IRQ_SOURCES-1:0];
        end
    end

    always_ff @(posedge clk_2) begin
        if (!i_rst_n) begin
            o_irq_n <= 1'b1;
        end else begin
            o_irq_n <= ~|w_pend;                    // Any masked source pulls it low
        end
    end

    always_comb begin
        case (i_reg_off)
            IRQ_MASK: o_rdata = r_mask;
            IRQ_PEND: o_rdata = w_pend;
            default:  o_rdata = '0;
        endcase
    end

    // Line released whatever the source levels were during reset
    a_irq_n_after_reset : assert property (@(posedge clk_2)
        !i_rst_n |=> o_irq_n);

endmodule

// File: rtl/interval_timer.sv
`timescale 1ns/100ps

module interval_timer (
    input  logic                               clk_2,
    input  logic                               i_rst_n,
    input  logic                               i_cs,
    input  logic                               i_rwb,
    input  logic                               i_valid,
    input  logic [1:0]                         i_reg_off,
    input  logic [super6502_pkg::DATA_W-1:0]   i_wdata,
    output logic [super6502_pkg::DATA_W-1:0]   o_rdata,
    output logic                               o_irq
);
    import super6502_pkg::*;

    logic [15:0] r_reload;
    logic [15:0] r_count;
    logic [1:0]  r_ctrl;                            // [0] enable, [1] irq enable
    logic        r_flag;
    logic        w_wr;
    logic        w_load;
    logic        w_clear;
    logic        w_expire;

    assign w_wr     = i_valid & ~i_rwb & i_cs;
    assign w_load   = w_wr & (i_reg_off == TMR_CTRL) & i_wdata[0];
    assign w_clear  = w_wr & (i_reg_off == TMR_STAT) & i_wdata[0];
    assign w_expire = r_ctrl[0] & ~w_load & (r_count == 16'h0000);

    //////////////////////////////////////////////////
    // Register writes
    //////////////////////////////////////////////////

    always_ff @(posedge clk_2) begin
        if (!i_rst_n) begin
            r_reload <= '0;
            r_ctrl   <= '0;
        end else if (w_wr) begin
            case (i_reg_off)
                TMR_LO:   r_reload[7:0]  <= i_wdata;
                TMR_HI:   r_reload[15:8] <= i_wdata;
                TMR_CTRL: r_ctrl         <= i_wdata[1:0];
                default:  ;
            endcase
        end
    end

    //////////////////////////////////////////////////
    // Down counter and expired flag
    //////////////////////////////////////////////////

    always_ff @(posedge clk_2) begin
        if (!i_rst_n) begin
            r_count <= '0;
            r_flag  <= 1'b0;
        end else begin
            if (w_load) begin
                r_count <= r_reload;                // Start on the enable write
            end else if (w_expire) begin
                r_count <= r_reload;
            end else if (r_ctrl[0]) begin
                r_count <= r_count - 16'd1;
            end

            if (w_expire) begin
                r_flag <= 1'b1;                     // Expiry beats a same-edge clear
            end else if (w_clear) begin
                r_flag <= 1'b0;
            end
        end
    end

    assign o_irq = r_flag & r_ctrl[1];

    always_comb begin
        case (i_reg_off)
            TMR_LO:   o_rdata = r_count[7:0];
            TMR_HI:   o_rdata = r_count[15:8];
            TMR_CTRL: o_rdata = {{(DATA_W-2){1'b0}}, r_ctrl};
            TMR_STAT: o_rdata = {{(DATA_W-1){1'b0}}, r_flag};
            default:  o_rdata = '0;
        endcase
    end

    a_no_set_when_disabled : assert property (@(posedge clk_2) disable iff (!i_rst_n)
        !r_ctrl[0] |=> !$rose(r_flag));

endmodule

// File: rtl/mult_unit.sv
`timescale 1ns/100ps

module mult_unit (
    input  logic                               clk_2,
    input  logic                               i_rst_n,
    input  logic                               i_cs,
    input  logic                               i_rwb,
    input  logic                               i_valid,
    input  logic [1:0]                         i_reg_off,
    input  logic [super6502_pkg::DATA_W-1:0]   i_wdata,
    output logic [super6502_pkg::DATA_W-1:0]   o_rdata
);
    import super6502_pkg::*;

    logic [DATA_W-1:0]   r_a;
    logic [DATA_W-1:0]   r_b;
    logic [2*DATA_W-1:0] r_prod;
    logic                w_wr;

    assign w_wr = i_valid & ~i_rwb & i_cs;

    //////////////////////////////////////////////////
    // Operand and product registers
    //////////////////////////////////////////////////

    always_ff @(posedge clk_2) begin
        if (!i_rst_n) begin
            r_a <= '0;
            r_b <= '0;
        end else if (w_wr) begin
            case (i_reg_off)
                MULT_A:  r_a <= i_wdata;
                MULT_B:  r_b <= i_wdata;
                default: ;                          // Product bytes are read only
            endcase
        end
    end

    // Recomputed every edge so it follows the latest operands
    always_ff @(posedge clk_2) begin
        if (!i_rst_n) begin
            r_prod <= '0;
        end else begin
            r_prod <= {{DATA_W{1'b0}}, r_a} * {{DATA_W{1'b0}}, r_b};
        end
    end

    //////////////////////////////////////////////////
    // Read back
    //////////////////////////////////////////////////

    always_comb begin
        case (i_reg_off)
            MULT_A:   o_rdata = r_a;
            MULT_B:   o_rdata = r_b;
            MULT_PLO: o_rdata = r_prod[DATA_W-1:0];
            MULT_PHI: o_rdata = r_prod[2*DATA_W-1:DATA_W];
            default:  o_rdata = '0;
        endcase
    end

endmodule

// File: rtl/bus_addr_decode.sv
`timescale 1ns/100ps

module bus_addr_decode (
    input  super6502_pkg::bus_req_t    i_req,
    output super6502_pkg::periph_sel_t o_sel
);
    import super6502_pkg::*;

    logic w_mult_hit;
    logic w_timer_hit;
    logic w_irq_hit;

    // Four byte windows match on addr[15:2]
    assign w_mult_hit  = (i_req.addr[15:2] == MULT_BASE[15:2]);
    assign w_timer_hit = (i_req.addr[15:2] == TIMER_BASE[15:2]);

    // Interrupt controller only spans two bytes
    assign w_irq_hit   = (i_req.addr[15:1] == IRQ_BASE[15:1]);

    always_comb begin
        o_sel          = '0;
        o_sel.mult_cs  = w_mult_hit;
        o_sel.timer_cs = w_timer_hit;
        o_sel.irq_cs   = w_irq_hit;
        o_sel.reg_off  = i_req.addr[1:0];          // Low bits pass straight through
    end

    //////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////

    // Overlapping windows in the address map would show up here
    always_comb begin
        a_sel_onehot0 : assert ($onehot0({o_sel.mult_cs, o_sel.timer_cs, o_sel.irq_cs}))
        else $error("More than one peripheral select at addr %h", i_req.addr);
    end

endmodule

// File: rtl/super6502_pkg.sv
package super6502_pkg;

    //////////////////////////////////////////////////
    // Bus types
    //////////////////////////////////////////////////

    localparam int DATA_W = 8;                      // CPU data bus width

    typedef struct packed {
        logic [15:0]       addr;
        logic [DATA_W-1:0] wdata;
        logic              rwb;                     // 1 read, 0 write
        logic              valid;                   // Cycle strobe
        logic              spare;
    } bus_req_t;

    typedef struct packed {
        logic       mult_cs;
        logic       timer_cs;
        logic       irq_cs;
        logic [1:0] reg_off;                        // Offset within peripheral
    } periph_sel_t;

    //////////////////////////////////////////////////
    // Address map
    //////////////////////////////////////////////////

    localparam logic [15:0] MULT_BASE  = 16'h7FF0;  // 4 bytes
    localparam logic [15:0] TIMER_BASE = 16'h7FF4;  // 4 bytes
    localparam logic [15:0] IRQ_BASE   = 16'h7FF8;  // 2 bytes

    localparam int IRQ_SOURCES   = 8;
    localparam int IRQ_SRC_TIMER = 0;
    localparam int IRQ_SRC_EXT   = 1;

    //////////////////////////////////////////////////
    // Register offsets
    //////////////////////////////////////////////////

    localparam logic [1:0] MULT_A   = 2'd0;
    localparam logic [1:0] MULT_B   = 2'd1;
    localparam logic [1:0] MULT_PLO = 2'd2;
    localparam logic [1:0] MULT_PHI = 2'd3;

    localparam logic [1:0] TMR_LO   = 2'd0;         // Reload low, reads count low
    localparam logic [1:0] TMR_HI   = 2'd1;
    localparam logic [1:0] TMR_CTRL = 2'd2;         // Bit 0 enable, bit 1 irq enable
    localparam logic [1:0] TMR_STAT = 2'd3;         // Bit 0 expired, write 1 to clear

    localparam logic [1:0] IRQ_MASK = 2'd0;
    localparam logic [1:0] IRQ_PEND = 2'd1;

endpackage
